// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int IMM_W     = 16;
    localparam int REG_IDXW  = 3;
    localparam int REG_COUNT = 8;
    localparam int RAM_ADDRW = 10;
    // byte addressed, one word per entry
    localparam int RAM_WORDS = 256;

    // instruction field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int RD_HI  = 26;
    localparam int RD_LO  = 24;
    localparam int RA_HI  = 23;
    localparam int RA_LO  = 21;
    localparam int RB_HI  = 20;
    localparam int RB_LO  = 18;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [RAM_ADDRW-1:0] addr_t;
    typedef logic [REG_IDXW-1:0]  reg_idx_t;
    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [4:0] {
        OP_ADD      = 5'h00,
        OP_SUB      = 5'h01,
        OP_AND      = 5'h02,
        OP_OR       = 5'h03,
        OP_XOR      = 5'h04,
        OP_ADDI     = 5'h05,
        OP_LOAD     = 5'h06,
        OP_STORE    = 5'h07,
        OP_JMP_REL  = 5'h08,
        OP_BZ       = 5'h09,
        OP_JMP_ABS  = 5'h0a,
        OP_PUTC_IMM = 5'h0b,
        OP_PUTC_REG = 5'h0c,
        OP_HALT_IMM = 5'h0d,
        OP_HALT_REG = 5'h0e
    } op_t;

    // undefined code, runs as a no-op
    localparam op_t OP_NOP = op_t'(5'h1f);

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {
        BUS_NOP,
        BUS_FETCH,
        BUS_STORE
    } bus_op_t;

    typedef enum logic [2:0] {
        CU_IDLE,
        CU_FETCH,
        CU_DECODE,
        CU_LOAD_OPERANDS,
        CU_EXECUTE,
        CU_INCREMENT,
        CU_HALTED
    } cu_state_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_ifs.sv ====
`default_nettype none

interface ram_if;
    cpu_pkg::addr_t addr;
    logic           we;
    cpu_pkg::word_t wdata;
    cpu_pkg::word_t rdata;

    modport master (output addr, output we, output wdata, input rdata);
    modport slave (input addr, input we, input wdata, output rdata);
endinterface

interface reg_if;
    cpu_pkg::reg_idx_t raddr0;
    cpu_pkg::reg_idx_t raddr1;
    cpu_pkg::reg_idx_t waddr;
    logic              we;
    cpu_pkg::word_t    wdata;
    cpu_pkg::word_t    rdata0;
    cpu_pkg::word_t    rdata1;

    modport master (output raddr0, output raddr1, output waddr, output we, output wdata,
                    input rdata0, input rdata1);
    modport slave (input raddr0, input raddr1, input waddr, input we, input wdata,
                   output rdata0, output rdata1);
endinterface

interface alu_if;
    cpu_pkg::alu_op_t op;
    cpu_pkg::word_t   a;
    cpu_pkg::word_t   b;
    cpu_pkg::word_t   s;
    // status register outputs
    logic             zf;
    logic             cf;

    modport master (output op, output a, output b, input s, input zf, input cf);
    modport slave (input op, input a, input b, output s, output zf, output cf);
endinterface

interface instr_if;
    cpu_pkg::op_t      op;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t ra;
    cpu_pkg::reg_idx_t rb;
    cpu_pkg::word_t    imm;
    logic              branch_taken;
    cpu_pkg::alu_op_t  alu_op;

    modport source (output op, output rd, output ra, output rb, output imm,
                    output branch_taken, output alu_op);
    modport sink (input op, input rd, input ra, input rb, input imm,
                  input branch_taken, input alu_op);
endinterface

`default_nettype wire

// ==== rtl/decoder.sv ====
`default_nettype none

module decoder (
    input  logic           clk,
    input  logic           rst,
    input  logic           capture,
    input  cpu_pkg::word_t ir,
    input  logic           zf,
    instr_if.source        instr
);
    cpu_pkg::op_t     op;
    cpu_pkg::imm_t    imm_raw;
    cpu_pkg::alu_op_t alu_op;
    logic             taken;

    always_comb begin
        op      = cpu_pkg::op_t'(ir[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO]);
        imm_raw = ir[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO];
        // flags are final here, the previous instruction has retired
        taken   = (op == cpu_pkg::OP_JMP_REL) || ((op == cpu_pkg::OP_BZ) && zf);

        case (op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI: begin
                alu_op = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OP_SUB: begin
                alu_op = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_AND: begin
                alu_op = cpu_pkg::ALU_AND;
            end
            cpu_pkg::OP_OR: begin
                alu_op = cpu_pkg::ALU_OR;
            end
            cpu_pkg::OP_XOR: begin
                alu_op = cpu_pkg::ALU_XOR;
            end
            default: begin
                alu_op = cpu_pkg::ALU_NOP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr.op           <= cpu_pkg::OP_NOP;
            instr.alu_op       <= cpu_pkg::ALU_NOP;
            instr.branch_taken <= 1'b0;
        end else if (capture) begin
            instr.op           <= op;
            instr.alu_op       <= alu_op;
            instr.branch_taken <= taken;
        end
    end

    // operand fields
    always_ff @(posedge clk) begin
        if (capture) begin
            instr.rd  <= ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
            instr.ra  <= ir[cpu_pkg::RA_HI:cpu_pkg::RA_LO];
            instr.rb  <= ir[cpu_pkg::RB_HI:cpu_pkg::RB_LO];
            instr.imm <= {{(cpu_pkg::WORD_W - cpu_pkg::IMM_W){imm_raw[cpu_pkg::IMM_W-1]}},
                          imm_raw};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input logic  clk,
    input logic  rst,
    alu_if.slave alu
);
    // bit WORD_W is carry out, or borrow for sub
    logic [cpu_pkg::WORD_W:0] wide;

    always_comb begin
        case (alu.op)
            cpu_pkg::ALU_ADD: begin
                wide = {1'b0, alu.a} + {1'b0, alu.b};
            end
            cpu_pkg::ALU_SUB: begin
                wide = {1'b0, alu.a} - {1'b0, alu.b};
            end
            cpu_pkg::ALU_AND: begin
                wide = {1'b0, alu.a & alu.b};
            end
            cpu_pkg::ALU_OR: begin
                wide = {1'b0, alu.a | alu.b};
            end
            cpu_pkg::ALU_XOR: begin
                wide = {1'b0, alu.a ^ alu.b};
            end
            default: begin
                wide = '0;
            end
        endcase
        alu.s = wide[cpu_pkg::WORD_W-1:0];
    end

    // status register
    always_ff @(posedge clk) begin
        if (rst) begin
            alu.zf <= 1'b0;
            alu.cf <= 1'b0;
        end else if (alu.op != cpu_pkg::ALU_NOP) begin
            alu.zf <= (wide[cpu_pkg::WORD_W-1:0] == '0);
            alu.cf <= wide[cpu_pkg::WORD_W];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file (
    input logic  clk,
    reg_if.slave rf
);
    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    // asynchronous read ports
    assign rf.rdata0 = regs[rf.raddr0];
    assign rf.rdata1 = regs[rf.raddr1];

    always_ff @(posedge clk) begin
        if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram.sv ====
`default_nettype none

module ram (
    input  logic           clk,
    ram_if.slave           core,
    input  logic           load_we,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::word_t load_data
);
    cpu_pkg::word_t mem [cpu_pkg::RAM_WORDS];

    // word index, low two address bits ignored
    logic [cpu_pkg::RAM_ADDRW-3:0] core_idx;
    logic [cpu_pkg::RAM_ADDRW-3:0] load_idx;

    assign core_idx = core.addr[cpu_pkg::RAM_ADDRW-1:2];
    assign load_idx = load_addr[cpu_pkg::RAM_ADDRW-1:2];

    always_ff @(posedge clk) begin
        if (core.we) begin
            mem[core_idx] <= core.wdata;
        end else if (load_we) begin
            mem[load_idx] <= load_data;
        end
    end

    // one cycle read latency, old data on a same-cycle write
    always_ff @(posedge clk) begin
        core.rdata <= mem[core_idx];
    end

endmodule

`default_nettype wire

// ==== rtl/cu.sv ====
`default_nettype none

module cu (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    ram_if.master          mem,
    reg_if.master          rf,
    alu_if.master          alu,
    output logic           putc_valid,
    input  logic           putc_ready,
    output cpu_pkg::byte_t putc_char,
    output logic           halted,
    output cpu_pkg::byte_t exit_code,
    output logic           load_ready
);
    cpu_pkg::cu_state_t state;
    cpu_pkg::cu_state_t state_next;
    cpu_pkg::addr_t     ip;
    cpu_pkg::addr_t     ip_next;
    cpu_pkg::addr_t     ip_ret;
    cpu_pkg::addr_t     data_addr;
    cpu_pkg::bus_op_t   bus_op;
    logic               capture;
    logic               is_putc;
    logic               is_halt;
    logic               writes_reg;
    logic               inc_done;
    logic               launch;

    instr_if instr ();

    assign capture = (state == cpu_pkg::CU_DECODE);

    decoder decoder_i (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .ir      (mem.rdata),
        .zf      (alu.zf),
        .instr   (instr)
    );

    // instruction class
    always_comb begin
        bus_op     = cpu_pkg::BUS_NOP;
        is_putc    = 1'b0;
        is_halt    = 1'b0;
        writes_reg = 1'b0;
        case (instr.op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
            cpu_pkg::OP_XOR, cpu_pkg::OP_ADDI, cpu_pkg::OP_JMP_ABS: begin
                writes_reg = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                bus_op     = cpu_pkg::BUS_FETCH;
                writes_reg = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                bus_op = cpu_pkg::BUS_STORE;
            end
            cpu_pkg::OP_PUTC_IMM, cpu_pkg::OP_PUTC_REG: begin
                is_putc = 1'b1;
            end
            cpu_pkg::OP_HALT_IMM, cpu_pkg::OP_HALT_REG: begin
                is_halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign load_ready = (state == cpu_pkg::CU_IDLE) || (state == cpu_pkg::CU_HALTED);
    assign launch     = load_ready && start;
    // putc holds the last state until the character is taken
    assign inc_done   = (state == cpu_pkg::CU_INCREMENT) && (!is_putc || putc_ready);

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::CU_IDLE, cpu_pkg::CU_HALTED: begin
                if (start) begin
                    state_next = cpu_pkg::CU_FETCH;
                end
            end
            cpu_pkg::CU_FETCH: begin
                state_next = cpu_pkg::CU_DECODE;
            end
            cpu_pkg::CU_DECODE: begin
                state_next = cpu_pkg::CU_LOAD_OPERANDS;
            end
            cpu_pkg::CU_LOAD_OPERANDS: begin
                state_next = cpu_pkg::CU_EXECUTE;
            end
            cpu_pkg::CU_EXECUTE: begin
                state_next = cpu_pkg::CU_INCREMENT;
            end
            cpu_pkg::CU_INCREMENT: begin
                if (inc_done) begin
                    state_next = is_halt ? cpu_pkg::CU_HALTED : cpu_pkg::CU_FETCH;
                end
            end
            default: begin
                state_next = cpu_pkg::CU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= cpu_pkg::CU_IDLE;
            ip        <= '0;
            exit_code <= '0;
        end else begin
            state <= state_next;
            if (launch) begin
                ip        <= '0;
                exit_code <= '0;
            end else if (inc_done) begin
                ip <= ip_next;
                if (is_halt) begin
                    exit_code <= (instr.op == cpu_pkg::OP_HALT_IMM)
                               ? instr.imm[cpu_pkg::BYTE_W-1:0]
                               : rf.rdata0[cpu_pkg::BYTE_W-1:0];
                end
            end
        end
    end

    assign ip_ret    = ip + cpu_pkg::addr_t'(4);
    assign data_addr = rf.rdata0[cpu_pkg::RAM_ADDRW-1:0] + instr.imm[cpu_pkg::RAM_ADDRW-1:0];

    always_comb begin
        if (instr.branch_taken) begin
            // word offset from the branch itself
            ip_next = ip + {instr.imm[cpu_pkg::RAM_ADDRW-3:0], 2'b00};
        end else if (instr.op == cpu_pkg::OP_JMP_ABS) begin
            ip_next = rf.rdata0[cpu_pkg::RAM_ADDRW-1:0];
        end else begin
            ip_next = ip_ret;
        end
    end

    // ram port steering
    always_comb begin
        mem.addr  = (state == cpu_pkg::CU_FETCH) ? ip : data_addr;
        mem.we    = inc_done && (bus_op == cpu_pkg::BUS_STORE);
        mem.wdata = rf.rdata1;
    end

    // operand fields sit at fixed positions for every class
    always_comb begin
        rf.raddr0 = instr.ra;
        rf.raddr1 = instr.rb;
        rf.waddr  = instr.rd;
        rf.we     = inc_done && writes_reg;
        if (bus_op == cpu_pkg::BUS_FETCH) begin
            rf.wdata = mem.rdata;
        end else if (instr.op == cpu_pkg::OP_JMP_ABS) begin
            rf.wdata = cpu_pkg::word_t'(ip_ret);
        end else begin
            rf.wdata = alu.s;
        end
    end

    // op only in the last state, flags commit once
    always_comb begin
        alu.op = (state == cpu_pkg::CU_INCREMENT) ? instr.alu_op : cpu_pkg::ALU_NOP;
        alu.a  = rf.rdata0;
        alu.b  = (instr.op == cpu_pkg::OP_ADDI) ? instr.imm : rf.rdata1;
    end

    assign putc_valid = (state == cpu_pkg::CU_INCREMENT) && is_putc;
    assign putc_char  = (instr.op == cpu_pkg::OP_PUTC_IMM) ? instr.imm[cpu_pkg::BYTE_W-1:0]
                                                            : rf.rdata0[cpu_pkg::BYTE_W-1:0];
    assign halted     = (state == cpu_pkg::CU_HALTED);

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           load_valid,
    output logic           load_ready,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::word_t load_data,
    output logic           putc_valid,
    input  logic           putc_ready,
    output cpu_pkg::byte_t putc_char,
    output logic           halted,
    output cpu_pkg::byte_t exit_code
);
    logic load_we;

    ram_if mem_bus ();
    reg_if rf_bus ();
    alu_if alu_bus ();

    // program words only land while the core is stopped
    assign load_we = load_valid && load_ready;

    cu cu_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .mem        (mem_bus),
        .rf         (rf_bus),
        .alu        (alu_bus),
        .putc_valid (putc_valid),
        .putc_ready (putc_ready),
        .putc_char  (putc_char),
        .halted     (halted),
        .exit_code  (exit_code),
        .load_ready (load_ready)
    );

    ram ram_i (
        .clk       (clk),
        .core      (mem_bus),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    reg_file reg_file_i (
        .clk (clk),
        .rf  (rf_bus)
    );

    alu alu_i (
        .clk (clk),
        .rst (rst),
        .alu (alu_bus)
    );

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
`default_nettype none

module clk_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    // period 8
    always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/cpu_props.sv ====
`default_nettype none

module cpu_props (
    input logic               clk,
    input logic               rst,
    input logic               start,
    input cpu_pkg::cu_state_t state,
    input logic               putc_valid,
    input logic               putc_ready,
    input cpu_pkg::byte_t     putc_char,
    input logic               load_ready
);
    // stalled character must hold
    putc_hold: assert property (@(posedge clk) disable iff (rst)
        (putc_valid && !putc_ready) |=> (putc_valid && $stable(putc_char)))
        else $error("putc_valid dropped or putc_char changed before putc_ready");

    // a taken start closes the load port
    load_gate: assert property (@(posedge clk) disable iff (rst)
        (load_ready && start) |=> !load_ready)
        else $error("load_ready still high after the core started");

    state_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state))
        else $error("control state is unknown");

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
`default_nettype none

module tb_cpu;
    localparam int MAX_WORDS       = 64;
    localparam int NUM_PROGS       = 3;
    localparam int WATCHDOG_CYCLES = 8 + NUM_PROGS * (MAX_WORDS * 5 * 4 + MAX_WORDS + 8);

    logic           clk;
    logic           rst;
    logic           start;
    logic           load_valid;
    logic           load_ready;
    cpu_pkg::addr_t load_addr;
    cpu_pkg::word_t load_data;
    logic           putc_valid;
    logic           putc_ready;
    cpu_pkg::byte_t putc_char;
    logic           halted;
    cpu_pkg::byte_t exit_code;

    logic [31:0]    lfsr;
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t model_mem [cpu_pkg::RAM_WORDS];
    cpu_pkg::word_t model_regs [cpu_pkg::REG_COUNT];
    logic           model_zf;
    cpu_pkg::byte_t exp_chars [$];
    cpu_pkg::byte_t exp_exit;

    clk_gen clk_gen_i (
        .clk (clk)
    );

    cpu_top cpu_top_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .putc_valid (putc_valid),
        .putc_ready (putc_ready),
        .putc_char  (putc_char),
        .halted     (halted),
        .exit_code  (exit_code)
    );

    bind cu cpu_props cpu_props_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .state      (state),
        .putc_valid (putc_valid),
        .putc_ready (putc_ready),
        .putc_char  (putc_char),
        .load_ready (load_ready)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'ha300_0000;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic cpu_pkg::word_t enc(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [2:0] rb,
                                           input logic [15:0] imm);
        return {op, rd, ra, rb, 2'b00, imm};
    endfunction

    function automatic logic [4:0] rand_alu_op();
        logic [2:0] k;
        k = 3'(rand_bits(3) % 6);
        return 5'(k);
    endfunction

    task automatic build_program(input int num);
        int          sel;
        int          base;
        int          n;
        logic [2:0]  rd;
        logic [2:0]  ra;
        logic [15:0] off;
        prog.delete();
        // 2-state xor clears r0 whatever it held
        prog.push_back(enc(cpu_pkg::OP_XOR, 3'd0, 3'd0, 3'd0, 16'h0));
        for (int r = 1; r < 7; r++) begin
            prog.push_back(enc(cpu_pkg::OP_ADDI, 3'(r), 3'd0, 3'd0, 16'(rand_bits(16))));
        end
        prog.push_back(enc(cpu_pkg::OP_ADDI, 3'd0, 3'd0, 3'd0, 16'(rand_bits(16))));
        // r7 is the data base, byte 512
        prog.push_back(enc(cpu_pkg::OP_XOR, 3'd7, 3'd7, 3'd7, 16'h0));
        prog.push_back(enc(cpu_pkg::OP_ADDI, 3'd7, 3'd7, 3'd0, 16'd512));
        while (prog.size() < 48) begin
            sel = int'(rand_bits(3));
            rd  = 3'(rand_bits(3) % 6);
            case (sel)
                2: begin
                    if (rand_bits(1) == 32'd1) begin
                        ra = 3'(rand_bits(3));
                        prog.push_back(enc(cpu_pkg::OP_SUB, rd, ra, ra, 16'h0));
                    end else begin
                        prog.push_back(enc(rand_alu_op(), rd, 3'(rand_bits(3)),
                                           3'(rand_bits(3)), 16'(rand_bits(16))));
                    end
                    prog.push_back(enc(cpu_pkg::OP_BZ, 3'd0, 3'd0, 3'd0, 16'd2));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h7a));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h6e));
                end
                3: begin
                    off = 16'(rand_bits(7) * 4);
                    prog.push_back(enc(cpu_pkg::OP_STORE, 3'd0, 3'd7, 3'(rand_bits(3)), off));
                    prog.push_back(enc(cpu_pkg::OP_LOAD, rd, 3'd7, 3'd0, off));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_REG, 3'd0, rd, 3'd0, 16'h0));
                end
                4: begin
                    n = int'(rand_bits(2)) + 1;
                    prog.push_back(enc(cpu_pkg::OP_JMP_REL, 3'd0, 3'd0, 3'd0, 16'(n + 1)));
                    for (int i = 0; i < n; i++) begin
                        prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h23));
                    end
                end
                5: begin
                    base = prog.size();
                    prog.push_back(enc(cpu_pkg::OP_XOR, 3'd6, 3'd6, 3'd6, 16'h0));
                    prog.push_back(enc(cpu_pkg::OP_ADDI, 3'd6, 3'd6, 3'd0, 16'((base + 5) * 4)));
                    prog.push_back(enc(cpu_pkg::OP_JMP_ABS, 3'd5, 3'd6, 3'd0, 16'h0));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h23));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h23));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0, 16'h4a));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_REG, 3'd0, 3'd5, 3'd0, 16'h0));
                end
                6: begin
                    // undefined opcodes 0x10 and up
                    prog.push_back(enc(5'h10 | 5'(rand_bits(4)), rd, 3'd0, 3'd0, 16'h0));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_IMM, 3'd0, 3'd0, 3'd0,
                                       16'(32 + rand_bits(6))));
                end
                default: begin
                    prog.push_back(enc(rand_alu_op(), rd, 3'(rand_bits(3)), 3'(rand_bits(3)),
                                       16'(rand_bits(16))));
                    prog.push_back(enc(cpu_pkg::OP_PUTC_REG, 3'd0, rd, 3'd0, 16'h0));
                end
            endcase
        end
        if (num == 1) begin
            prog.push_back(enc(cpu_pkg::OP_HALT_REG, 3'd0, 3'(rand_bits(3)), 3'd0, 16'h0));
        end else begin
            prog.push_back(enc(cpu_pkg::OP_HALT_IMM, 3'd0, 3'd0, 3'd0, 16'(rand_bits(8))));
        end
    endtask

    // instruction level interpreter
    task automatic run_model();
        cpu_pkg::word_t w;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t imm;
        logic [32:0]    wide;
        logic [9:0]     ip;
        logic [9:0]     nip;
        logic [9:0]     ea;
        logic [4:0]     op;
        logic [2:0]     rd;
        logic           alu_res;
        logic           done;
        int             steps;
        exp_chars.delete();
        ip    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * MAX_WORDS) begin
            w       = model_mem[ip[9:2]];
            op      = w[31:27];
            rd      = w[26:24];
            a       = model_regs[w[23:21]];
            b       = model_regs[w[20:18]];
            imm     = {{16{w[15]}}, w[15:0]};
            ea      = a[9:0] + imm[9:0];
            nip     = ip + 10'd4;
            alu_res = 1'b1;
            wide    = '0;
            case (op)
                cpu_pkg::OP_ADD:  wide = {1'b0, a} + {1'b0, b};
                cpu_pkg::OP_ADDI: wide = {1'b0, a} + {1'b0, imm};
                cpu_pkg::OP_SUB:  wide = {1'b0, a} - {1'b0, b};
                cpu_pkg::OP_AND:  wide = {1'b0, a & b};
                cpu_pkg::OP_OR:   wide = {1'b0, a | b};
                cpu_pkg::OP_XOR:  wide = {1'b0, a ^ b};
                default:          alu_res = 1'b0;
            endcase
            if (alu_res) begin
                model_regs[rd] = wide[31:0];
                model_zf       = (wide[31:0] == 32'h0);
            end
            case (op)
                cpu_pkg::OP_LOAD:     model_regs[rd] = model_mem[ea[9:2]];
                cpu_pkg::OP_STORE:    model_mem[ea[9:2]] = b;
                cpu_pkg::OP_JMP_REL:  nip = ip + {imm[7:0], 2'b00};
                cpu_pkg::OP_BZ: begin
                    if (model_zf) begin
                        nip = ip + {imm[7:0], 2'b00};
                    end
                end
                cpu_pkg::OP_JMP_ABS: begin
                    nip            = a[9:0];
                    model_regs[rd] = {22'h0, ip + 10'd4};
                end
                cpu_pkg::OP_PUTC_IMM: exp_chars.push_back(imm[7:0]);
                cpu_pkg::OP_PUTC_REG: exp_chars.push_back(a[7:0]);
                cpu_pkg::OP_HALT_IMM: begin
                    exp_exit = imm[7:0];
                    done     = 1'b1;
                end
                cpu_pkg::OP_HALT_REG: begin
                    exp_exit = a[7:0];
                    done     = 1'b1;
                end
                default: begin
                end
            endcase
            ip = nip;
            steps++;
        end
        if (!done) begin
            fail_now("reference model did not reach a halt");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            load_valid = 1'b1;
            load_addr  = cpu_pkg::addr_t'(i * 4);
            load_data  = prog[i];
            @(negedge clk);
            assert (load_ready) else fail_now("load port not ready while the core is stopped");
            @(posedge clk);
            #1;
        end
        load_valid = 1'b0;
    endtask

    task automatic watch_run();
        int   idx;
        int   after;
        logic seen_halt;
        idx       = 0;
        after     = 0;
        seen_halt = 1'b0;
        start     = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (after < 4) begin
            @(negedge clk);
            if (!halted) begin
                assert (!load_ready) else fail_now("load port open while a program runs");
            end
            if (seen_halt) begin
                assert (!putc_valid) else fail_now("putc_valid raised after halt");
                after++;
            end
            if (putc_valid && putc_ready) begin
                assert (idx < exp_chars.size()) else fail_now("more characters than expected");
                assert (putc_char == exp_chars[idx])
                    else fail_now($sformatf("Fail putc_char got %h expected %h",
                                            putc_char, exp_chars[idx]));
                idx++;
            end
            if (halted && !seen_halt) begin
                seen_halt = 1'b1;
                assert (idx == exp_chars.size())
                    else fail_now($sformatf("halted after %0d of %0d characters",
                                            idx, exp_chars.size()));
                assert (exit_code == exp_exit)
                    else fail_now($sformatf("Fail exit_code got %h expected %h",
                                            exit_code, exp_exit));
            end
            @(posedge clk);
            #1;
            // low about a third of the time
            putc_ready = (rand_bits(3) >= 32'd3);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 8);
        fail_now("watchdog expired before all programs finished");
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        putc_ready = 1'b0;
        lfsr       = 32'heecf_86cc;
        model_zf   = 1'b0;
        exp_exit   = '0;
        for (int i = 0; i < cpu_pkg::RAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < NUM_PROGS; k++) begin
            build_program(k);
            for (int i = 0; i < prog.size(); i++) begin
                model_mem[i] = prog[i];
            end
            run_model();
            load_program();
            watch_run();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
rtl/cpu_pkg.sv
rtl/cpu_ifs.sv
rtl/decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/ram.sv
rtl/cu.sv
rtl/cpu_top.sv
tb/clk_gen.sv
tb/cpu_props.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cpu -f cpu_top.f -o sim_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed"
    exit $status
fi

./obj_dir/sim_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
